/* files.f */
+incdir+source
source/microwordPkg.sv
source/diagPkg.sv
source/nextAddress.sv
source/sbrStack.sv
source/controlStore.sv
source/diagRegs.sv
source/microSequencer.sv
test/microSequencerTb.sv

/* run.sh */
#!/bin/bash
# Build and run the microSequencer regression with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  --top-module microSequencerTb \
  -f files.f \
  -o simv

./obj_dir/simv | tee sim.log

if grep -q "Regression failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

exit 0

/* source/controlStore.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sequencer_cfg.svh"

module controlStore #(
  parameter int WORDS = 1 << `CRAM_ADR_BITS
) (
  input  logic                       CLK,
  input  logic                       csWriteEn,
  input  logic [`CRAM_ADR_BITS-1:0]  csWriteAddr,
  input  logic [`DIAG_DATA_BITS-1:0] csWriteData,
  input  logic [`CRAM_ADR_BITS-1:0]  craAddr,
  output logic [`DIAG_DATA_BITS-1:0] microword
);

  ////////////////////////////////////////
  // Writable control store
  ////////////////////////////////////////

  logic [`DIAG_DATA_BITS-1:0] cram [WORDS];

  // Loaded only from the diagnostic side
  always_ff @(posedge CLK) begin
    if (csWriteEn) begin
      cram[csWriteAddr] <= csWriteData;
    end
  end

  // Asynchronous read so the next address
  // is formed in the same cycle
  assign microword = cram[craAddr];

endmodule

`default_nettype wire

/* source/diagPkg.sv */
`default_nettype none

package diagPkg;

  // Functions carried by a diagnostic strobe
  typedef enum logic [2:0] {
    diagNop       = 3'd0,
    diagWriteAddr = 3'd1,
    diagWriteWord = 3'd2,
    diagLoadAddr  = 3'd3,
    diagRun       = 3'd4,
    diagHalt      = 3'd5,
    diagRead      = 3'd6
  } diagFunc_t;

  // Readback source, taken from diagData[1:0]
  typedef enum logic [1:0] {
    readAddr, readStackTop, readStackDepth
  } readSel_t;

endpackage

`default_nettype wire

/* source/diagRegs.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sequencer_cfg.svh"

module diagRegs #(
  parameter int DEPTH_BITS = $clog2(`STACK_DEPTH) + 1,
  parameter int DATA_BITS  = `DIAG_DATA_BITS
) (
  input  logic                      CLK,
  input  logic                      RESET,
  input  logic                      diagStrobe,
  input  diagPkg::diagFunc_t        diagFunc,
  input  logic [DATA_BITS-1:0]      diagData,
  input  logic [`CRAM_ADR_BITS-1:0] craAddr,
  input  logic [`CRAM_ADR_BITS-1:0] returnAddr,
  input  logic [DEPTH_BITS-1:0]     stackDepth,
  output logic                      running,
  output logic                      csWriteEn,
  output logic [`CRAM_ADR_BITS-1:0] csWriteAddr,
  output logic [DATA_BITS-1:0]      csWriteData,
  output logic                      addrLoad,
  output logic [`CRAM_ADR_BITS-1:0] addrLoadValue,
  output logic [DATA_BITS-1:0]      diagReadData
);
  import diagPkg::*;

  logic [`CRAM_ADR_BITS-1:0] writePtr;
  logic                      isWriteAddr;
  logic                      isWriteWord;
  logic                      isLoadAddr;
  logic                      isRead;
  readSel_t                  readSel;
  logic [DATA_BITS-1:0]      readValue;

  // Function decode, qualified by the strobe
  assign isWriteAddr = diagStrobe && (diagFunc == diagWriteAddr);
  assign isWriteWord = diagStrobe && (diagFunc == diagWriteWord);
  assign isLoadAddr  = diagStrobe && (diagFunc == diagLoadAddr);
  assign isRead      = diagStrobe && (diagFunc == diagRead);
  assign readSel     = readSel_t'(diagData[1:0]);

  always_comb begin
    case (readSel)
      readAddr:       readValue = DATA_BITS'(craAddr);
      readStackTop:   readValue = DATA_BITS'(returnAddr);
      readStackDepth: readValue = DATA_BITS'(stackDepth);
      default:        readValue = '0;
    endcase
  end

  ////////////////////////////////////////
  // Run state, strobes and readback
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (RESET) begin
      running      <= 1'b0;
      csWriteEn    <= 1'b0;
      addrLoad     <= 1'b0;
      writePtr     <= '0;
      diagReadData <= '0;
    end else begin
      if (diagStrobe && diagFunc == diagRun) begin
        running <= 1'b1;
      end else if (diagStrobe && diagFunc == diagHalt) begin
        running <= 1'b0;
      end
      // Auto increment after each word
      if (isWriteAddr) begin
        writePtr <= diagData[`CRAM_ADR_BITS-1:0];
      end else if (isWriteWord) begin
        writePtr <= writePtr + 1'b1;
      end
      csWriteEn <= isWriteWord;
      // Address load is ignored while sequencing
      addrLoad  <= isLoadAddr && !running;
      if (isRead) begin
        diagReadData <= readValue;
      end
    end
  end

  // Write and load payloads
  always_ff @(posedge CLK) begin
    if (isWriteWord) begin
      csWriteAddr <= writePtr;
      csWriteData <= diagData;
    end
    if (isLoadAddr) begin
      addrLoadValue <= diagData[`CRAM_ADR_BITS-1:0];
    end
  end

endmodule

`default_nettype wire

/* source/microSequencer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sequencer_cfg.svh"

module microSequencer #(
  parameter int DEPTH_BITS = $clog2(`STACK_DEPTH) + 1
) (
  input  logic                       CLK,
  input  logic                       RESET,
  input  logic [`CRAM_ADR_BITS-1:0]  irDispatch,
  input  logic [7:0]                 condFlags,
  input  logic                       forceTrap,
  input  logic                       diagStrobe,
  input  diagPkg::diagFunc_t         diagFunc,
  input  logic [`DIAG_DATA_BITS-1:0] diagData,
  output logic [`CRAM_ADR_BITS-1:0]  craAddr,
  output logic [`DIAG_DATA_BITS-1:0] microword,
  output logic                       running,
  output logic [`DIAG_DATA_BITS-1:0] diagReadData
);

  logic                       push;
  logic                       pop;
  logic [`CRAM_ADR_BITS-1:0]  pushValue;
  logic [`CRAM_ADR_BITS-1:0]  returnAddr;
  logic [DEPTH_BITS-1:0]      stackDepth;
  logic                       csWriteEn;
  logic [`CRAM_ADR_BITS-1:0]  csWriteAddr;
  logic [`DIAG_DATA_BITS-1:0] csWriteData;
  logic                       addrLoad;
  logic [`CRAM_ADR_BITS-1:0]  addrLoadValue;

  ////////////////////////////////////////
  // Sequencer core
  ////////////////////////////////////////

  nextAddress u_nextAddress (
    .CLK          (CLK),
    .RESET        (RESET),
    .microword    (microword),
    .irDispatch   (irDispatch),
    .condFlags    (condFlags),
    .forceTrap    (forceTrap),
    .running      (running),
    .addrLoad     (addrLoad),
    .addrLoadValue(addrLoadValue),
    .returnAddr   (returnAddr),
    .craAddr      (craAddr),
    .push         (push),
    .pop          (pop),
    .pushValue    (pushValue)
  );

  sbrStack #(
    .DEPTH_BITS(DEPTH_BITS)
  ) u_sbrStack (
    .CLK       (CLK),
    .RESET     (RESET),
    .push      (push),
    .pop       (pop),
    .pushValue (pushValue),
    .returnAddr(returnAddr),
    .stackDepth(stackDepth)
  );

  controlStore u_controlStore (
    .CLK        (CLK),
    .csWriteEn  (csWriteEn),
    .csWriteAddr(csWriteAddr),
    .csWriteData(csWriteData),
    .craAddr    (craAddr),
    .microword  (microword)
  );

  // Diagnostic side
  diagRegs #(
    .DEPTH_BITS(DEPTH_BITS)
  ) u_diagRegs (
    .CLK          (CLK),
    .RESET        (RESET),
    .diagStrobe   (diagStrobe),
    .diagFunc     (diagFunc),
    .diagData     (diagData),
    .craAddr      (craAddr),
    .returnAddr   (returnAddr),
    .stackDepth   (stackDepth),
    .running      (running),
    .csWriteEn    (csWriteEn),
    .csWriteAddr  (csWriteAddr),
    .csWriteData  (csWriteData),
    .addrLoad     (addrLoad),
    .addrLoadValue(addrLoadValue),
    .diagReadData (diagReadData)
  );

endmodule

`default_nettype wire

/* source/microwordPkg.sv */
`default_nettype none
`include "sequencer_cfg.svh"

package microwordPkg;

  ////////////////////////////////////////
  // Microword layout, MSB to LSB
  ////////////////////////////////////////

  // call | disp | cond | jump
  localparam int J_BITS    = `CRAM_ADR_BITS;
  localparam int COND_BITS = 3;
  localparam int DISP_BITS = 3;

  localparam int J_LSB    = 0;
  localparam int COND_LSB = J_LSB + J_BITS;
  localparam int DISP_LSB = COND_LSB + COND_BITS;
  localparam int CALL_BIT = DISP_LSB + DISP_BITS;

  // Dispatch forms ORed into the jump field
  typedef enum logic [DISP_BITS-1:0] {
    dispNone   = 3'd0,
    dispIr     = 3'd1,
    dispReturn = 3'd2,
    dispSkip   = 3'd3
  } dispSel_t;

  // Skip condition, flag index or constant one
  typedef enum logic [COND_BITS-1:0] {
    skipC0, skipC1, skipC2, skipC3,
    skipC4, skipC5, skipC6, skipAlways
  } skipCond_t;

endpackage

`default_nettype wire

/* source/nextAddress.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sequencer_cfg.svh"

module nextAddress (
  input  logic                       CLK,
  input  logic                       RESET,
  input  logic [`DIAG_DATA_BITS-1:0] microword,
  input  logic [`CRAM_ADR_BITS-1:0]  irDispatch,
  input  logic [7:0]                 condFlags,
  input  logic                       forceTrap,
  input  logic                       running,
  input  logic                       addrLoad,
  input  logic [`CRAM_ADR_BITS-1:0]  addrLoadValue,
  input  logic [`CRAM_ADR_BITS-1:0]  returnAddr,
  output logic [`CRAM_ADR_BITS-1:0]  craAddr,
  output logic                       push,
  output logic                       pop,
  output logic [`CRAM_ADR_BITS-1:0]  pushValue
);
  import microwordPkg::*;

  logic                      callBit;
  dispSel_t                  dispSel;
  skipCond_t                 skipCond;
  logic [J_BITS-1:0]         jField;
  logic                      skipBit;
  logic [`CRAM_ADR_BITS-1:0] dispValue;
  logic [`CRAM_ADR_BITS-1:0] nextAddr;

  // Field decode of the current microword
  assign callBit  = microword[CALL_BIT];
  assign dispSel  = dispSel_t'(microword[DISP_LSB +: DISP_BITS]);
  assign skipCond = skipCond_t'(microword[COND_LSB +: COND_BITS]);
  assign jField   = microword[J_LSB +: J_BITS];

  // Skip lands in bit 0 only
  always_comb begin
    if (skipCond == skipAlways) begin
      skipBit = 1'b1;
    end else begin
      skipBit = condFlags[skipCond];
    end
  end

  ////////////////////////////////////////
  // Dispatch mux
  ////////////////////////////////////////

  always_comb begin
    case (dispSel)
      dispIr:     dispValue = irDispatch;
      dispReturn: dispValue = returnAddr;
      dispSkip:   dispValue = {{(`CRAM_ADR_BITS-1){1'b0}}, skipBit};
      default:    dispValue = '0;
    endcase
  end

  // Trap overrides everything and goes to 3777
  assign nextAddr = forceTrap ? '1 : (jField | dispValue);

  // Stack controls only move in running cycles
  assign push      = running & (forceTrap | callBit);
  assign pop       = running & ~forceTrap & (dispSel == dispReturn);
  assign pushValue = craAddr;

  // addrLoad only arrives while halted
  always_ff @(posedge CLK) begin
    if (RESET) begin
      craAddr <= '0;
    end else if (addrLoad) begin
      craAddr <= addrLoadValue;
    end else if (running) begin
      craAddr <= nextAddr;
    end
  end

endmodule

`default_nettype wire

/* source/sbrStack.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sequencer_cfg.svh"

module sbrStack #(
  parameter int PTR_BITS   = $clog2(`STACK_DEPTH),
  parameter int DEPTH_BITS = PTR_BITS + 1
) (
  input  logic                      CLK,
  input  logic                      RESET,
  input  logic                      push,
  input  logic                      pop,
  input  logic [`CRAM_ADR_BITS-1:0] pushValue,
  output logic [`CRAM_ADR_BITS-1:0] returnAddr,
  output logic [DEPTH_BITS-1:0]     stackDepth
);

  logic [`CRAM_ADR_BITS-1:0] stackMem [`STACK_DEPTH];
  logic [PTR_BITS-1:0]       stackPtr;
  logic [PTR_BITS-1:0]       topPtr;
  logic [PTR_BITS-1:0]       writePtr;
  logic [DEPTH_BITS-1:0]     depthAfterPop;

  // Pointer addresses the next free slot, top sits just below
  assign topPtr     = stackPtr - 1'b1;
  assign returnAddr = stackMem[topPtr];

  // Pop applies first, so a call+return overwrites the top
  assign writePtr = pop ? topPtr : stackPtr;

  always_ff @(posedge CLK) begin
    if (push) begin
      stackMem[writePtr] <= pushValue;
    end
  end

  // Circular, so overflow simply wraps over the oldest entry
  always_ff @(posedge CLK) begin
    if (RESET) begin
      stackPtr <= '0;
    end else if (push && !pop) begin
      stackPtr <= stackPtr + 1'b1;
    end else if (pop && !push) begin
      stackPtr <= topPtr;
    end
  end

  ////////////////////////////////////////
  // Depth counter, saturates at full
  ////////////////////////////////////////

  always_comb begin
    depthAfterPop = stackDepth;
    if (pop && stackDepth != '0) begin
      depthAfterPop = stackDepth - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      stackDepth <= '0;
    end else if (push && depthAfterPop != DEPTH_BITS'(`STACK_DEPTH)) begin
      stackDepth <= depthAfterPop + 1'b1;
    end else begin
      stackDepth <= depthAfterPop;
    end
  end

endmodule

`default_nettype wire

/* source/sequencer_cfg.svh */
`ifndef SEQUENCER_CFG_SVH
`define SEQUENCER_CFG_SVH

////////////////////////////////////////
// Sequencer sizing
////////////////////////////////////////

// Control RAM address width, 2048 microwords
`define CRAM_ADR_BITS 11

// Entries in the call/return stack
`define STACK_DEPTH 16

// Diagnostic data width, same as one microword
`define DIAG_DATA_BITS 18

`endif

/* test/microSequencerTb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "sequencer_cfg.svh"

module microSequencerTb;
  import diagPkg::*;

  logic                       CLK = 1'b0;
  logic                       RESET;
  logic [`CRAM_ADR_BITS-1:0]  irDispatch;
  logic [7:0]                 condFlags;
  logic                       forceTrap;
  logic                       diagStrobe;
  diagFunc_t                  diagFunc;
  logic [`DIAG_DATA_BITS-1:0] diagData;
  logic [`CRAM_ADR_BITS-1:0]  craAddr;
  logic [`DIAG_DATA_BITS-1:0] microword;
  logic                       running;
  logic [`DIAG_DATA_BITS-1:0] diagReadData;

  // Records from the stimulus file
  bit          recIsDiag [64];
  logic [19:0] recA [64];
  logic [19:0] recB [64];
  logic [19:0] recC [64];
  logic [19:0] recD [64];
  int          recordCount;

  int checkCount = 0;
  int errorCount = 0;
  int cycleCount = 0;
  int cycleLimit = 100;

  // Reference model state
  logic [17:0] mCram [2048];
  bit          mValid [2048];
  logic [10:0] mStack [16];
  logic [3:0]  mSp;
  logic [4:0]  mDepth;
  logic [10:0] mAddr;
  bit          mRunning;
  logic [10:0] mPtr;
  bit          pendWrite;
  logic [10:0] pendWriteAddr;
  logic [17:0] pendWriteData;
  bit          pendLoad;
  logic [10:0] pendLoadValue;
  logic [17:0] mReadData;

  // Expectation from the file for the record just applied
  int          expectKind;
  logic [19:0] expectValue;

  microSequencer u_microSequencer (
    .CLK         (CLK),
    .RESET       (RESET),
    .irDispatch  (irDispatch),
    .condFlags   (condFlags),
    .forceTrap   (forceTrap),
    .diagStrobe  (diagStrobe),
    .diagFunc    (diagFunc),
    .diagData    (diagData),
    .craAddr     (craAddr),
    .microword   (microword),
    .running     (running),
    .diagReadData(diagReadData)
  );

  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    begin
      checkCount++;
      if (actual !== expected) begin
        errorCount++;
        $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////

  task automatic loadRecords(output bit ok);
    int             fd;
    int             code;
    bit             done;
    logic [63:0]    tag;
    logic [8*128:1] lineBuf;
    logic [19:0]    a;
    logic [19:0]    b;
    logic [19:0]    c;
    logic [19:0]    d;
    begin
      ok = 1'b0;
      done = 1'b0;
      recordCount = 0;
      fd = $fopen("test/sequencerInput.txt", "r");
      if (fd != 0) begin
        ok = 1'b1;
        while (!done) begin
          tag = '0;
          a = '0;
          b = '0;
          c = '0;
          d = '0;
          code = $fscanf(fd, "%s", tag);
          if (code != 1) begin
            done = 1'b1;
          end else if (tag == "#") begin
            code = $fgets(lineBuf, fd);
          end else if ((tag == "D" || tag == "R") && recordCount < 64) begin
            if (tag == "D") begin
              code = $fscanf(fd, "%h %h %h", a, b, c);
            end else begin
              code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
            end
            recIsDiag[recordCount] = (tag == "D");
            recA[recordCount] = a;
            recB[recordCount] = b;
            recC[recordCount] = c;
            recD[recordCount] = d;
            recordCount++;
          end else begin
            $display("Stimulus file holds an unknown record or too many records");
            ok = 1'b0;
            done = 1'b1;
          end
        end
        $fclose(fd);
      end
    end
  endtask

  task automatic driveRecord(input int k);
    begin
      diagStrobe <= recIsDiag[k];
      if (recIsDiag[k]) begin
        diagFunc   <= diagFunc_t'(recA[k][2:0]);
        diagData   <= recB[k][17:0];
        irDispatch <= '0;
        condFlags  <= '0;
        forceTrap  <= 1'b0;
      end else begin
        diagFunc   <= diagNop;
        diagData   <= '0;
        irDispatch <= recA[k][10:0];
        condFlags  <= recB[k][7:0];
        forceTrap  <= recC[k][0];
      end
    end
  endtask

  task automatic driveIdle();
    begin
      diagStrobe <= 1'b0;
      diagFunc   <= diagNop;
      diagData   <= '0;
      irDispatch <= '0;
      condFlags  <= '0;
      forceTrap  <= 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // Reference model, one clock edge
  ////////////////////////////////////////

  task automatic applyModel(input int k);
    logic        strobe;
    logic [2:0]  func;
    logic [17:0] data;
    logic [10:0] ir;
    logic [7:0]  flags;
    logic        trap;
    logic [17:0] word;
    logic [2:0]  disp;
    logic [2:0]  cond;
    logic [10:0] top;
    logic [10:0] dispVal;
    logic [10:0] next;
    logic [10:0] oldAddr;
    bit          wasRunning;
    begin
      strobe = recIsDiag[k];
      func = strobe ? recA[k][2:0] : 3'd0;
      data = strobe ? recB[k][17:0] : 18'd0;
      ir = strobe ? 11'd0 : recA[k][10:0];
      flags = strobe ? 8'd0 : recB[k][7:0];
      trap = strobe ? 1'b0 : recC[k][0];
      wasRunning = mRunning;
      oldAddr = mAddr;
      // Layout is call, dispatch, condition, jump from the top bit down
      word = mCram[mAddr];
      disp = word[16:14];
      cond = word[13:11];
      top = mStack[mSp - 4'd1];
      case (disp)
        3'd1: dispVal = ir;
        3'd2: dispVal = top;
        3'd3: dispVal = {10'd0, (cond == 3'd7) ? 1'b1 : flags[cond]};
        default: dispVal = '0;
      endcase
      next = trap ? 11'h7ff : (word[10:0] | dispVal);
      if (strobe && func == 3'd6) begin
        case (data[1:0])
          2'd0: mReadData = {7'd0, mAddr};
          2'd1: mReadData = {7'd0, top};
          2'd2: mReadData = {13'd0, mDepth};
          default: mReadData = '0;
        endcase
      end
      if (pendWrite) begin
        mCram[pendWriteAddr] = pendWriteData;
        mValid[pendWriteAddr] = 1'b1;
      end
      if (pendLoad) begin
        mAddr = pendLoadValue;
      end else if (wasRunning) begin
        mAddr = next;
      end
      // Pop goes first when a call and a return meet
      if (wasRunning) begin
        if (!trap && disp == 3'd2) begin
          mSp = mSp - 4'd1;
          if (mDepth != 0) mDepth = mDepth - 5'd1;
        end
        if (trap || word[17]) begin
          mStack[mSp] = oldAddr;
          mSp = mSp + 4'd1;
          if (mDepth != 5'd16) mDepth = mDepth + 5'd1;
        end
      end
      pendWrite = strobe && func == 3'd2;
      pendWriteAddr = mPtr;
      pendWriteData = data;
      pendLoad = strobe && func == 3'd3 && !wasRunning;
      pendLoadValue = data[10:0];
      if (strobe && func == 3'd1) mPtr = data[10:0];
      if (strobe && func == 3'd2) mPtr = mPtr + 11'd1;
      if (strobe && func == 3'd4) mRunning = 1'b1;
      if (strobe && func == 3'd5) mRunning = 1'b0;
      // The file also carries expected values
      expectValue = strobe ? recC[k] : recD[k];
      expectKind = (expectValue == 20'hfffff) ? 0 : (strobe ? 2 : 1);
    end
  endtask

  task automatic checkState();
    begin
      checkValue(craAddr, mAddr, "craAddr");
      checkValue(running, mRunning, "running");
      checkValue(diagReadData, mReadData, "diagReadData");
      if (mValid[mAddr]) begin
        checkValue(microword, mCram[mAddr], "microword");
      end
      if (expectKind == 1) begin
        checkValue(craAddr, expectValue, "craAddr against file");
      end else if (expectKind == 2) begin
        checkValue(diagReadData, expectValue, "diagReadData against file");
      end
    end
  endtask

  initial begin
    int k;
    bit fileOk;
    RESET = 1'b1;
    irDispatch = '0;
    condFlags = '0;
    forceTrap = 1'b0;
    diagStrobe = 1'b0;
    diagFunc = diagNop;
    diagData = '0;
    mSp = '0;
    mDepth = '0;
    mAddr = '0;
    mRunning = 1'b0;
    mPtr = '0;
    pendWrite = 1'b0;
    pendLoad = 1'b0;
    mReadData = '0;
    expectKind = 0;
    expectValue = '0;
    loadRecords(fileOk);
    if (!fileOk) begin
      $display("Could not read the stimulus file test/sequencerInput.txt");
      $display("Regression failed");
      $finish;
    end else begin
      cycleLimit = 2 * recordCount + 100;
      repeat (10) @(posedge CLK);
      RESET <= 1'b0;
      for (k = 0; k < recordCount; k++) begin
        @(posedge CLK);
        driveRecord(k);
        @(negedge CLK);
        checkState();
        applyModel(k);
      end
      @(posedge CLK);
      driveIdle();
      @(negedge CLK);
      checkState();
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
        $display("Regression passed");
      end else begin
        $display("Regression failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* test/sequencerInput.txt */
# D diagFunc diagData expectedReadback (hex, fffff means no check)
# R irDispatch condFlags forceTrap expectedCraAddr (hex, fffff means no check)
D 1 007ff fffff
D 2 08002 fffff
D 2 00001 fffff
D 2 04002 fffff
D 2 0d002 fffff
D 2 0f804 fffff
D 2 00004 fffff
D 2 20008 fffff
D 2 2000a fffff
D 2 00004 fffff
D 2 2000c fffff
D 2 08002 fffff
D 2 0000a fffff
D 2 00000 fffff
D 2 2000e fffff
D 2 08001 fffff
D 2 08001 fffff
D 3 0000e fffff
D 3 00000 fffff
D 4 00000 fffff
R 000 00 0 00001
R 002 00 0 00002
R 000 fb 0 00002
R 000 04 0 00003
R 000 00 0 00005
R 000 00 0 00008
R 000 00 0 0000c
R 000 00 0 0000e
D 6 00002 00003
R 000 00 0 00009
D 6 00001 00005
R 000 00 0 00004
R 000 00 0 00004
R 000 00 1 007ff
R 000 00 0 00006
R 000 00 0 0000a
D 3 00000 fffff
R 000 00 0 0000a
D 5 00000 fffff
R 000 00 1 0000a
R 000 00 0 0000a
D 6 00000 0000a
D 6 00001 00006
D 6 00002 00001
R 000 00 0 0000a
